//--- hw/eth_pkg.sv
`default_nettype none

package eth_pkg;

  // mac address, byte 5 is the first byte on the wire.
  typedef logic [5:0][7:0] mac_addr_t;
  typedef logic [15:0]     ethertype_t;

  // header in wire order, dst lands in the top bits.
  typedef struct packed {
    mac_addr_t  dst;
    mac_addr_t  src;
    ethertype_t ethertype;
  } mac_hdr_t;

  localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
  localparam logic [7:0] SFD_BYTE      = 8'hd5;

  localparam int HDR_LEN = 14; // dst + src + ethertype.
  localparam int FCS_LEN = 4;

  // reflected crc-32, register is not complemented at the end.
  localparam logic [31:0] CRC_POLY    = 32'hedb88320;
  localparam logic [31:0] CRC_INIT    = 32'hffffffff;
  localparam logic [31:0] CRC_RESIDUE = 32'hdebb20e3;

  localparam int MIN_PAYLOAD = 1;
  localparam int MAX_PAYLOAD = 1500;

  localparam int BUF_AW  = 11; // 2048 byte payload ram.
  localparam int DESC_AW = 2;  // 4 descriptors.

  typedef logic [10:0] len_t;

  localparam mac_addr_t BROADCAST_MAC = '1;

endpackage

`default_nettype wire

//--- hw/crc32_check.sv
`default_nettype none

module crc32_check (
  input  wire logic       clk,
  input  wire logic       fsm_rst,
  input  wire logic [7:0] dat,
  input  wire logic       val,
  input  wire logic       clr,
  output logic            ok
);

  logic [31:0] crc;

  // one byte through the reflected lfsr, lsb first.
  function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    r = c ^ {24'd0, d};
    for (int i = 0; i < 8; i++) begin
      if (r[0]) begin
        r = (r >> 1) ^ eth_pkg::CRC_POLY;
      end else begin
        r = r >> 1;
      end
    end
    return r;
  endfunction

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      crc <= eth_pkg::CRC_INIT;
    end else if (clr) begin
      crc <= eth_pkg::CRC_INIT; // clear wins over a byte.
    end else if (val) begin
      crc <= crc_byte(crc, dat);
    end
  end

  // data plus a correct fcs always leaves the same residue.
  assign ok = (crc == eth_pkg::CRC_RESIDUE);

endmodule

`default_nettype wire

//--- hw/mac_rx.sv
`default_nettype none

module mac_rx (
  input  wire logic       clk,
  input  wire logic       fsm_rst,
  input  wire logic [7:0] phy_dat,
  input  wire logic       phy_val,
  output logic [7:0]      rx_dat,
  output logic            rx_val,
  output eth_pkg::mac_hdr_t rx_hdr,
  output logic            rx_end,
  output logic            rx_good
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_PRE,
    S_HDR,
    S_BODY,
    S_DRAIN
  } state_t;

  state_t state;

  logic            phy_val_q;
  logic [3:0]      hdr_cnt;
  logic [11:0]     body_cnt; // saturates, oversize frames stay oversize.
  logic [3:0][7:0] dly;      // fcs hold-back.
  logic            crc_ok;
  logic            crc_clr;
  logic            crc_val;

  assign crc_clr = (state == S_IDLE) || (state == S_PRE);
  assign crc_val = phy_val && ((state == S_HDR) || (state == S_BODY));

  crc32_check u_crc (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .dat     (phy_dat),
    .val     (crc_val),
    .clr     (crc_clr),
    .ok      (crc_ok)
  );

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state     <= S_IDLE;
      phy_val_q <= 1'b0;
      hdr_cnt   <= '0;
      body_cnt  <= '0;
      rx_val    <= 1'b0;
      rx_end    <= 1'b0;
      rx_good   <= 1'b0;
    end else begin
      phy_val_q <= phy_val;
      rx_val    <= 1'b0;
      rx_end    <= 1'b0;
      case (state)
        S_IDLE, S_PRE: begin
          if (!phy_val) begin
            state <= S_IDLE;
          end else if (state == S_PRE || !phy_val_q) begin
            // idle only looks at the first byte of a window.
            if (phy_dat == eth_pkg::SFD_BYTE) begin
              state    <= S_HDR;
              hdr_cnt  <= '0;
              body_cnt <= '0;
            end else if (phy_dat == eth_pkg::PREAMBLE_BYTE) begin
              state <= S_PRE;
            end else begin
              state <= S_IDLE; // junk, sit out the rest of the window.
            end
          end
        end
        S_HDR: begin
          if (!phy_val) begin
            state <= S_DRAIN; // short header, verdict will be bad.
          end else begin
            hdr_cnt <= hdr_cnt + 4'd1;
            if (hdr_cnt == 4'(eth_pkg::HDR_LEN - 1)) state <= S_BODY;
          end
        end
        S_BODY: begin
          if (!phy_val) begin
            state <= S_DRAIN;
          end else begin
            if (body_cnt != '1) body_cnt <= body_cnt + 12'd1;
            rx_val <= (body_cnt >= 12'(eth_pkg::FCS_LEN)); // oldest byte is payload.
          end
        end
        S_DRAIN: begin
          state   <= S_IDLE;
          rx_end  <= 1'b1;
          rx_good <= crc_ok &&
                     (hdr_cnt == 4'(eth_pkg::HDR_LEN)) &&
                     (body_cnt >= 12'(eth_pkg::FCS_LEN + eth_pkg::MIN_PAYLOAD)) &&
                     (body_cnt <= 12'(eth_pkg::FCS_LEN + eth_pkg::MAX_PAYLOAD));
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // header shift register, first byte ends up in dst byte 5.
  always_ff @(posedge clk) begin
    if (state == S_HDR && phy_val) begin
      rx_hdr <= eth_pkg::mac_hdr_t'({rx_hdr[8*eth_pkg::HDR_LEN-9:0], phy_dat});
    end
  end

  // body bytes sit four deep, the fcs never leaves the line.
  always_ff @(posedge clk) begin
    if (state == S_BODY && phy_val) begin
      dly    <= {dly[2:0], phy_dat};
      rx_dat <= dly[3];
    end
  end

endmodule

`default_nettype wire

//--- hw/frame_buffer.sv
`default_nettype none

module frame_buffer (
  input  wire logic              clk,
  input  wire logic              fsm_rst,
  input  wire logic [7:0]        rx_dat,
  input  wire logic              rx_val,
  input  wire eth_pkg::mac_hdr_t rx_hdr,
  input  wire logic              rx_end,
  input  wire logic              rx_good,
  input  wire logic              desc_pop,
  input  wire logic              rd_en,
  output logic                   desc_val,
  output eth_pkg::mac_hdr_t      desc_hdr,
  output eth_pkg::len_t          desc_len,
  output logic [7:0]             rd_dat
);

  localparam int DEPTH = 2 ** eth_pkg::BUF_AW;
  localparam int QLEN  = 2 ** eth_pkg::DESC_AW;

  logic [7:0] mem [0:DEPTH-1];

  // pointers carry one extra bit to tell full from empty.
  logic [eth_pkg::BUF_AW:0] wr_com;  // end of the last committed frame.
  logic [eth_pkg::BUF_AW:0] wr_spec; // write position of the frame in flight.
  logic [eth_pkg::BUF_AW:0] rd_base; // start of the head frame.
  logic [eth_pkg::BUF_AW:0] rd_ptr;
  logic [eth_pkg::BUF_AW:0] used;
  logic                     buf_full;
  logic                     ovf;
  logic                     wr_ok;

  eth_pkg::mac_hdr_t        q_hdr [0:QLEN-1];
  eth_pkg::len_t            q_len [0:QLEN-1];
  logic [eth_pkg::DESC_AW:0] q_wr;
  logic [eth_pkg::DESC_AW:0] q_rd;
  logic [eth_pkg::DESC_AW:0] q_used;
  logic                     q_full;
  logic                     commit;
  eth_pkg::len_t            frame_len;

  // space is freed only when the head descriptor retires.
  assign used     = wr_spec - rd_base;
  assign buf_full = used[eth_pkg::BUF_AW];
  assign wr_ok    = rx_val && !ovf && !buf_full;

  assign q_used = q_wr - q_rd;
  assign q_full = q_used[eth_pkg::DESC_AW];

  assign frame_len = eth_pkg::len_t'(wr_spec - wr_com);
  assign commit    = rx_end && rx_good && !ovf && !q_full;

  assign desc_val = (q_wr != q_rd);
  assign desc_hdr = q_hdr[q_rd[eth_pkg::DESC_AW-1:0]];
  assign desc_len = q_len[q_rd[eth_pkg::DESC_AW-1:0]];

  // write side, speculative until the verdict arrives.
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wr_com  <= '0;
      wr_spec <= '0;
      ovf     <= 1'b0;
      q_wr    <= '0;
    end else if (rx_end) begin
      ovf <= 1'b0;
      if (commit) begin
        wr_com <= wr_spec;
        q_wr   <= q_wr + 1'b1;
      end else begin
        wr_spec <= wr_com; // rewind the whole frame.
      end
    end else if (rx_val) begin
      if (wr_ok) begin
        wr_spec <= wr_spec + 1'b1;
      end else begin
        ovf <= 1'b1; // rest of the frame is lost, rewind at the end.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok) mem[wr_spec[eth_pkg::BUF_AW-1:0]] <= rx_dat;
  end

  always_ff @(posedge clk) begin
    if (commit) begin
      q_hdr[q_wr[eth_pkg::DESC_AW-1:0]] <= rx_hdr;
      q_len[q_wr[eth_pkg::DESC_AW-1:0]] <= frame_len;
    end
  end

  // read side.
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      rd_base <= '0;
      rd_ptr  <= '0;
      q_rd    <= '0;
    end else if (desc_pop) begin
      // full or partial read alike, jump to the next frame.
      rd_base <= rd_base + (eth_pkg::BUF_AW + 1)'(desc_len);
      rd_ptr  <= rd_base + (eth_pkg::BUF_AW + 1)'(desc_len);
      q_rd    <= q_rd + 1'b1;
    end else if (rd_en) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) rd_dat <= mem[rd_ptr[eth_pkg::BUF_AW-1:0]];
  end

endmodule

`default_nettype wire

//--- hw/rx_dispatch.sv
`default_nettype none

module rx_dispatch (
  input  wire logic               clk,
  input  wire logic               fsm_rst,
  input  wire eth_pkg::mac_addr_t local_mac,
  input  wire logic               desc_val,
  input  wire eth_pkg::mac_hdr_t  desc_hdr,
  input  wire eth_pkg::len_t      desc_len,
  input  wire logic [7:0]         rd_dat,
  output logic                    desc_pop,
  output logic                    rd_en,
  output logic [7:0]              m_dat,
  output logic                    m_val,
  output logic                    m_sof,
  output logic                    m_eof,
  output eth_pkg::mac_addr_t      m_src,
  output eth_pkg::ethertype_t     m_ethertype
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_POP
  } state_t;

  state_t        state;
  logic          hit;
  logic          rd_vq;    // rd_dat is valid this cycle.
  logic          sof_pend;
  eth_pkg::len_t rd_left;
  eth_pkg::len_t out_left;

  assign hit = (desc_hdr.dst == local_mac) || (desc_hdr.dst == eth_pkg::BROADCAST_MAC);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= S_IDLE;
      desc_pop <= 1'b0;
      rd_en    <= 1'b0;
      rd_vq    <= 1'b0;
      sof_pend <= 1'b0;
      rd_left  <= '0;
      out_left <= '0;
      m_val    <= 1'b0;
      m_sof    <= 1'b0;
      m_eof    <= 1'b0;
    end else begin
      desc_pop <= 1'b0;
      rd_vq    <= rd_en;
      m_val    <= rd_vq;
      m_sof    <= rd_vq && sof_pend;
      m_eof    <= rd_vq && (out_left == eth_pkg::len_t'(1));
      if (rd_vq) begin
        sof_pend <= 1'b0;
        out_left <= out_left - 1'b1;
      end
      case (state)
        S_IDLE: begin
          if (desc_val && hit) begin
            state    <= S_READ;
            rd_en    <= 1'b1;
            rd_left  <= desc_len - 1'b1;
            out_left <= desc_len;
            sof_pend <= 1'b1;
          end else if (desc_val) begin
            state    <= S_POP; // not ours, drop it.
            desc_pop <= 1'b1;
          end
        end
        S_READ: begin
          if (rd_left != '0) begin
            rd_en   <= 1'b1;
            rd_left <= rd_left - 1'b1;
          end else begin
            rd_en    <= 1'b0;
            desc_pop <= 1'b1; // last read issued.
            state    <= S_POP;
          end
        end
        S_POP: state <= S_IDLE; // queue head updates this cycle.
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    m_dat <= rd_dat;
    if (state == S_IDLE && desc_val && hit) begin
      m_src       <= desc_hdr.src;
      m_ethertype <= desc_hdr.ethertype;
    end
  end

endmodule

`default_nettype wire

//--- hw/eth_rx_top.sv
`default_nettype none

module eth_rx_top (
  input  wire logic               clk,
  input  wire logic               fsm_rst,
  input  wire logic [7:0]         phy_dat,
  input  wire logic               phy_val,
  input  wire eth_pkg::mac_addr_t local_mac,
  output logic [7:0]              m_dat,
  output logic                    m_val,
  output logic                    m_sof,
  output logic                    m_eof,
  output eth_pkg::mac_addr_t      m_src,
  output eth_pkg::ethertype_t     m_ethertype
);

  logic [7:0]        rx_dat;
  logic              rx_val;
  eth_pkg::mac_hdr_t rx_hdr;
  logic              rx_end;
  logic              rx_good;

  logic              desc_val;
  eth_pkg::mac_hdr_t desc_hdr;
  eth_pkg::len_t     desc_len;
  logic              desc_pop;
  logic              rd_en;
  logic [7:0]        rd_dat;

  mac_rx u_mac_rx (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .phy_dat (phy_dat),
    .phy_val (phy_val),
    .rx_dat  (rx_dat),
    .rx_val  (rx_val),
    .rx_hdr  (rx_hdr),
    .rx_end  (rx_end),
    .rx_good (rx_good)
  );

  frame_buffer u_buf (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .rx_dat   (rx_dat),
    .rx_val   (rx_val),
    .rx_hdr   (rx_hdr),
    .rx_end   (rx_end),
    .rx_good  (rx_good),
    .desc_pop (desc_pop),
    .rd_en    (rd_en),
    .desc_val (desc_val),
    .desc_hdr (desc_hdr),
    .desc_len (desc_len),
    .rd_dat   (rd_dat)
  );

  rx_dispatch u_disp (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .local_mac   (local_mac),
    .desc_val    (desc_val),
    .desc_hdr    (desc_hdr),
    .desc_len    (desc_len),
    .rd_dat      (rd_dat),
    .desc_pop    (desc_pop),
    .rd_en       (rd_en),
    .m_dat       (m_dat),
    .m_val       (m_val),
    .m_sof       (m_sof),
    .m_eof       (m_eof),
    .m_src       (m_src),
    .m_ethertype (m_ethertype)
  );

endmodule

`default_nettype wire

//--- sim/eth_rx_tb.sv
`default_nettype none

module eth_rx_tb;

  typedef enum logic [1:0] {DST_LOCAL, DST_BCAST, DST_OTHER} dst_kind_t;

  typedef struct packed {
    dst_kind_t           dst;
    eth_pkg::ethertype_t etype;
    eth_pkg::len_t       len;
    logic                bad_fcs;
    logic                bad_pre;
    logic                deliver;
  } frame_rec_t;

  localparam int NREC = 14;
  localparam int GAP  = 12; // idle cycles between frames.
  localparam eth_pkg::mac_addr_t MY_MAC    = 48'h02_00_5e_10_20_30;
  localparam eth_pkg::mac_addr_t OTHER_MAC = 48'h02_00_5e_99_88_77;

  logic                clk;
  logic                fsm_rst;
  logic [7:0]          phy_dat;
  logic                phy_val;
  eth_pkg::mac_addr_t  local_mac;
  logic [7:0]          m_dat;
  logic                m_val;
  logic                m_sof;
  logic                m_eof;
  eth_pkg::mac_addr_t  m_src;
  eth_pkg::ethertype_t m_ethertype;

  frame_rec_t          recs [NREC];
  logic [31:0]         lfsr;
  logic [7:0]          tx_q [$];      // wire bytes of the frame being sent.
  logic [7:0]          exp_bytes [$];
  eth_pkg::len_t       exp_len [$];
  eth_pkg::mac_addr_t  exp_src [$];
  eth_pkg::ethertype_t exp_type [$];
  int                  cycles;
  int                  limit;
  int                  delivered;
  logic                in_frame;
  eth_pkg::len_t       byte_idx;
  eth_pkg::len_t       cur_len;
  eth_pkg::mac_addr_t  cur_src;
  eth_pkg::ethertype_t cur_type;

  eth_rx_top UUT (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .phy_dat     (phy_dat),
    .phy_val     (phy_val),
    .local_mac   (local_mac),
    .m_dat       (m_dat),
    .m_val       (m_val),
    .m_sof       (m_sof),
    .m_eof       (m_eof),
    .m_src       (m_src),
    .m_ethertype (m_ethertype)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_failure();
    $display("sim failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_mac(input string name, input eth_pkg::mac_addr_t got,
                           input eth_pkg::mac_addr_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_type(input string name, input eth_pkg::ethertype_t got,
                            input eth_pkg::ethertype_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_count(input string name, input eth_pkg::len_t got,
                             input eth_pkg::len_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic load_table();
    recs[0]  = '{DST_LOCAL, 16'h0800, 11'd46,   1'b0, 1'b0, 1'b1};
    recs[1]  = '{DST_BCAST, 16'h0806, 11'd28,   1'b0, 1'b0, 1'b1};
    recs[2]  = '{DST_OTHER, 16'h0800, 11'd60,   1'b0, 1'b0, 1'b0};
    recs[3]  = '{DST_LOCAL, 16'h88b5, 11'd40,   1'b1, 1'b0, 1'b0}; // flipped fcs bit.
    recs[4]  = '{DST_LOCAL, 16'h0800, 11'd33,   1'b0, 1'b0, 1'b1};
    recs[5]  = '{DST_LOCAL, 16'h0800, 11'd50,   1'b0, 1'b1, 1'b0}; // junk in preamble.
    recs[6]  = '{DST_LOCAL, 16'h86dd, 11'd72,   1'b0, 1'b0, 1'b1};
    recs[7]  = '{DST_LOCAL, 16'h0800, 11'd64,   1'b0, 1'b0, 1'b1};
    recs[8]  = '{DST_BCAST, 16'h0806, 11'd100,  1'b0, 1'b0, 1'b1};
    recs[9]  = '{DST_LOCAL, 16'h0800, 11'd80,   1'b0, 1'b0, 1'b1};
    recs[10] = '{DST_LOCAL, 16'h88b5, 11'd120,  1'b0, 1'b0, 1'b1};
    recs[11] = '{DST_LOCAL, 16'h0800, 11'd90,   1'b0, 1'b0, 1'b1};
    recs[12] = '{DST_LOCAL, 16'h0800, 11'd1,    1'b0, 1'b0, 1'b1};
    recs[13] = '{DST_BCAST, 16'h0800, 11'd1500, 1'b0, 1'b0, 1'b1};
  endtask

  // fibonacci lfsr, taps 32 22 2 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    for (int k = 0; k < 8; k++) begin
      b[k] = lfsr[31];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // ethernet fcs over tx_q from the first header byte on.
  function automatic logic [31:0] ref_fcs(input int from);
    logic [31:0] c;
    logic        fb;
    c = 32'hffff_ffff;
    for (int i = from; i < tx_q.size(); i++) begin
      for (int k = 0; k < 8; k++) begin
        fb = c[0] ^ tx_q[i][k];
        c  = {1'b0, c[31:1]} ^ (fb ? 32'hedb8_8320 : 32'h0);
      end
    end
    return ~c;
  endfunction

  task automatic build_frame(input frame_rec_t r, input int idx);
    eth_pkg::mac_hdr_t hdr;
    logic [7:0]        b;
    logic [31:0]       fcs;
    tx_q = {};
    if (r.dst == DST_LOCAL) hdr.dst = MY_MAC;
    else if (r.dst == DST_BCAST) hdr.dst = 48'hffff_ffff_ffff;
    else hdr.dst = OTHER_MAC;
    hdr.src       = {40'h00_1b_21_00_00, 8'(idx)};
    hdr.ethertype = r.etype;
    repeat (7) tx_q.push_back(8'h55);
    if (r.bad_pre) tx_q[3] = 8'h5d;
    tx_q.push_back(8'hd5);
    for (int i = 13; i >= 0; i--) tx_q.push_back(hdr[8*i +: 8]); // dst byte 5 first.
    for (int i = 0; i < int'(r.len); i++) begin
      rand_byte(b);
      tx_q.push_back(b);
      if (r.deliver) exp_bytes.push_back(b);
    end
    fcs = ref_fcs(8);
    if (r.bad_fcs) fcs[idx % 32] = ~fcs[idx % 32];
    for (int i = 0; i < 4; i++) tx_q.push_back(fcs[8*i +: 8]); // lsb byte first.
    if (r.deliver) begin
      exp_len.push_back(r.len);
      exp_src.push_back(hdr.src);
      exp_type.push_back(r.etype);
    end
  endtask

  task automatic drive_frame();
    foreach (tx_q[i]) begin
      @(posedge clk);
      #2;
      phy_val = 1'b1;
      phy_dat = tx_q[i];
    end
    @(posedge clk);
    #2;
    phy_val = 1'b0;
    phy_dat = 8'h00;
    repeat (GAP) @(posedge clk);
  endtask

  // outputs change on the rising edge, look at them on the falling one.
  always @(negedge clk) begin
    if (!fsm_rst) begin
      if (m_val && m_sof) begin
        if (in_frame || exp_len.size() == 0) begin
          $display("unexpected m_sof, no delivered frame was due here");
          report_failure();
        end
        cur_len  = exp_len.pop_front();
        cur_src  = exp_src.pop_front();
        cur_type = exp_type.pop_front();
        in_frame = 1'b1;
        byte_idx = '0;
      end
      if (m_val) begin
        if (!in_frame) begin
          $display("m_val came outside a frame");
          report_failure();
        end
        // header fields hold for the whole frame.
        check_mac("m_src", m_src, cur_src);
        check_type("m_ethertype", m_ethertype, cur_type);
        check_byte("m_dat", m_dat, exp_bytes.pop_front());
        byte_idx = byte_idx + 1'b1;
        if (m_eof) begin
          check_count("frame length at m_eof", byte_idx, cur_len);
          in_frame  = 1'b0;
          delivered = delivered + 1;
        end else if (byte_idx == cur_len) begin
          $display("last byte of a frame came without m_eof");
          report_failure();
        end
      end else if (m_sof || m_eof) begin
        $display("m_sof or m_eof pulsed without m_val");
        report_failure();
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, expected frames were never delivered", cycles);
      report_failure();
    end
  end

  initial begin
    fsm_rst   = 1'b1;
    phy_val   = 1'b0;
    phy_dat   = 8'h00;
    local_mac = MY_MAC;
    lfsr      = 32'hee73_8bc0;
    cycles    = 0;
    delivered = 0;
    in_frame  = 1'b0;
    byte_idx  = '0;
    cur_len   = '0;
    load_table();
    limit = 0;
    foreach (recs[i]) begin
      // wire bytes, slack per frame, and the read-out of delivered payloads.
      limit += 8 + eth_pkg::HDR_LEN + int'(recs[i].len) + eth_pkg::FCS_LEN + 40;
      if (recs[i].deliver) begin
        limit += int'(recs[i].len);
      end
    end
    repeat (4) @(posedge clk);
    #2;
    fsm_rst = 1'b0;
    foreach (recs[i]) begin
      build_frame(recs[i], i);
      drive_frame();
    end
    while (exp_len.size() != 0 || in_frame) @(posedge clk);
    repeat (60) @(posedge clk); // catch stray output.
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
hw/eth_pkg.sv
hw/crc32_check.sv
hw/mac_rx.sv
hw/frame_buffer.sv
hw/rx_dispatch.sv
hw/eth_rx_top.sv
sim/eth_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the eth_rx testbench with verilator and runs it.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module eth_rx_tb -f all.f || exit 1
out=$(./obj_dir/Veth_rx_tb)
echo "$out"
echo "$out" | grep -qx "sim passed" && echo "PASS" || { echo "FAIL"; exit 1; }
